/* flist.f */
design/cmd_pkg.sv
design/cmd_frame_decoder.sv
design/settings_executor.sv
design/spi_transfer_seq.sv
design/usb_response_tx.sv
design/command_processor_top.sv
bench/spi_master_model.sv
bench/tb_command_processor.sv

/* bench/tb_command_processor.sv */
// testbench for the usb command processor
// directed frames for settings, reads, spi transfers and stream back-pressure
`timescale 1ns/1ns
`default_nettype none

module tb_command_processor;
   import cmd_pkg::*;

   localparam int N_TESTS     = 5;
   localparam int RSP_LIMIT   = 200;     // cycles to wait for a response beat
   localparam logic [31:0] EXP_VERSION = 32'd26;

   logic        clk50 = 1'b0;
   logic        pllreset2;
   logic        in_tvalid;
   logic [7:0]  in_tdata;
   logic        in_tready;
   logic        out_tready;
   logic        out_tvalid;
   logic [31:0] out_tdata;
   logic [3:0]  out_tkeep;
   logic        out_tlast;
   logic [7:0]  boardin;
   trig_cfg_t   trig;
   acq_cfg_t    acq;
   logic [7:0]  boardout;
   logic        fan_on;
   logic [1:0]  spi_mode;
   logic        spi_reset_l;
   logic        spi_tx_ready;
   logic        spi_rx_dv;
   logic [7:0]  spi_rx;
   logic [7:0]  spi_tx;
   logic        spi_tx_dv;
   logic [7:0]  spi_cs;
   logic [2:0]  spi_miso_sel;

   logic [31:0] lfsr = 32'h7098_67ce;
   string       cur_test;
   int          errors = 0;
   int          n_checks = 0;
   int          n_tests = 0;
   int          err_at_start;

   always #4 clk50 = ~clk50;

   command_processor_top dut (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_in_tvalid(in_tvalid), .i_in_tdata(in_tdata), .o_in_tready(in_tready),
      .i_out_tready(out_tready), .o_out_tvalid(out_tvalid), .o_out_tdata(out_tdata),
      .o_out_tkeep(out_tkeep), .o_out_tlast(out_tlast), .i_boardin(boardin),
      .o_trig(trig), .o_acq(acq), .o_boardout(boardout), .o_fan_on(fan_on),
      .o_spi_mode(spi_mode), .o_spi_reset_l(spi_reset_l),
      .i_spi_tx_ready(spi_tx_ready), .i_spi_rx_dv(spi_rx_dv), .i_spi_rx(spi_rx),
      .o_spi_tx(spi_tx), .o_spi_tx_dv(spi_tx_dv), .o_spi_cs(spi_cs),
      .o_spi_miso_sel(spi_miso_sel)
   );

   spi_master_model spi_model (
      .clk50(clk50), .pllreset2(pllreset2), .i_tx(spi_tx), .i_tx_dv(spi_tx_dv),
      .o_tx_ready(spi_tx_ready), .o_rx_dv(spi_rx_dv), .o_rx(spi_rx)
   );

   // galois form with taps for x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_step(lfsr);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic cmd_frame_t rand_frame(input cmd_op_e op);
      cmd_frame_t f;
      f.op = op;
      for (int i = 1; i <= 7; i++)
         f.args[i] = 8'(rand_bits(8));
      return f;
   endfunction

   task automatic check_word(input string what, input logic [31:0] exp, input logic [31:0] act);
      n_checks++;
      if (act !== exp) begin
         $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_trig(input string what, input trig_cfg_t exp, input trig_cfg_t act);
      n_checks++;
      if (act !== exp) begin
         $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_acq(input string what, input acq_cfg_t exp, input acq_cfg_t act);
      n_checks++;
      if (act !== exp) begin
         $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
      n_checks++;
      if (act !== exp) begin
         $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
         errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      $display("%s: %s", cur_test, msg);
      errors++;
   endtask

   task automatic begin_test(input string name);
      cur_test     = name;
      err_at_start = errors;
   endtask

   task automatic end_test();
      n_tests++;
      $display("test %-12s %s", cur_test, (errors == err_at_start) ? "ok" : "failed");
   endtask

   // op byte first and then args1 to args7
   task automatic send_frame(input cmd_frame_t f);
      for (int i = 0; i < FRAME_BYTES; i++) begin
         in_tvalid <= 1'b1;
         in_tdata  <= (i == 0) ? 8'(f.op) : f.args[i];
         @(posedge clk50);
         while (!in_tready)
            @(posedge clk50);
      end
      in_tvalid <= 1'b0;
   endtask

   task automatic get_rsp(input int stall, output logic [31:0] word);
      int waited;
      waited = 0;
      word   = '0;
      while (!out_tvalid && waited < RSP_LIMIT) begin
         @(posedge clk50);
         waited++;
      end
      if (!out_tvalid) begin
         report_failure("no response beat arrived in time");
         return;
      end
      word = out_tdata;
      if (out_tkeep !== 4'hf || out_tlast !== 1'b1)
         report_failure("response beat lacks full tkeep or tlast");
      for (int i = 0; i < stall; i++) begin
         @(posedge clk50);
         if (!out_tvalid || out_tdata !== word)
            report_failure("response beat changed while tready was low");
      end
      out_tready <= 1'b1;
      @(posedge clk50);  // beat taken here
      out_tready <= 1'b0;
   endtask

   task automatic run_cmd(input cmd_frame_t f, input int stall, output logic [31:0] word);
      send_frame(f);
      get_rsp(stall, word);
   endtask

   task automatic test_status_read();
      cmd_frame_t  f;
      logic [31:0] word;
      begin_test("status_read");
      check_byte("idle cs", 8'hff, spi_cs);
      check_byte("idle boardout", 8'h00, boardout);
      check_byte("idle flags", 8'b0000_1001,
                 {4'd0, in_tready, out_tvalid, spi_tx_dv, spi_reset_l});
      boardin <= 8'(rand_bits(8));
      f = rand_frame(OP_STATUS);
      f.args[1] = ST_VERSION;
      run_cmd(f, 0, word);
      check_word("status version", EXP_VERSION, word);
      f = rand_frame(OP_READ_REG);
      f.args[1] = REG_VERSION;
      run_cmd(f, 1, word);
      check_word("reg version", EXP_VERSION, word);
      f = rand_frame(OP_STATUS);
      f.args[1] = ST_BOARDIN;
      run_cmd(f, 0, word);
      check_word("status boardin", {24'd0, boardin}, word);
      f = rand_frame(OP_READ_REG);
      f.args[1] = 8'd7;  // no such register
      run_cmd(f, 0, word);
      check_word("unknown reg", 32'd0, word);
      f = rand_frame(OP_STATUS);
      f.args[1] = ST_FAN;
      f.args[2] = 8'd1;
      run_cmd(f, 0, word);
      check_word("fan old value", 32'd0, word);
      check_byte("fan on", 8'd1, {7'd0, fan_on});
      end_test();
   endtask

   task automatic test_trigger();
      cmd_frame_t  f;
      trig_cfg_t   exp_trig;
      logic [31:0] word;
      int          lo;
      int          up;
      begin_test("trigger");
      for (int n = 0; n < 3; n++) begin
         f  = rand_frame(OP_TRIG_SET);
         lo = (int'(f.args[1]) - int'(f.args[2]) - 128) * 16 + 8;
         up = (int'(f.args[1]) + int'(f.args[2]) - 128) * 16 + 8;
         exp_trig.lower_thresh = lo[11:0];
         exp_trig.upper_thresh = up[11:0];
         exp_trig.tot          = f.args[5];
         exp_trig.chan         = f.args[6][0];
         exp_trig.preoffset    = {f.args[3][1:0], f.args[4]};
         run_cmd(f, int'(rand_bits(2)), word);
         check_word("trig response", 32'd8, word);
         check_trig("trig config", exp_trig, trig);
         f = rand_frame(OP_READ_REG);
         f.args[1] = REG_UPPER;
         run_cmd(f, 0, word);
         check_word("upper readback", {20'd0, up[11:0]}, word);
         f.args[1] = REG_PREOFFSET;
         run_cmd(f, 0, word);
         check_word("preoffset readback", {22'd0, exp_trig.preoffset}, word);
      end
      end_test();
   endtask

   task automatic test_ds_board();
      cmd_frame_t  f;
      acq_cfg_t    exp_acq;
      logic [7:0]  exp_out;
      logic [31:0] word;
      begin_test("ds_board");
      f = rand_frame(OP_DS_SET);
      exp_acq.downsample = f.args[1][4:0];
      exp_acq.highres    = f.args[2][0];
      exp_acq.ds_merge   = f.args[3];
      run_cmd(f, 0, word);
      check_word("ds response", 32'd9, word);
      check_acq("acq config", exp_acq, acq);
      exp_out = 8'h00;  // nothing wrote it since reset
      for (int n = 0; n < 6; n++) begin
         f = rand_frame(OP_BOARDOUT);
         run_cmd(f, 0, word);
         check_word("boardout old byte", {24'd0, exp_out}, word);
         exp_out[f.args[1][2:0]] = f.args[2][0];
         check_byte("boardout", exp_out, boardout);
      end
      f = rand_frame(OP_SPI_MODE);
      run_cmd(f, 0, word);
      check_word("spi mode echo", {24'd0, f.args[1]}, word);
      check_byte("spi mode", {6'd0, f.args[1][1:0]}, {6'd0, spi_mode});
      end_test();
   endtask

   task automatic test_spi();
      cmd_frame_t  f;
      logic [31:0] word;
      logic [2:0]  cs;
      int          base;
      int          waited;
      begin_test("spi");
      for (int n = 2; n <= 4; n++) begin
         f  = rand_frame(OP_SPI);
         cs = f.args[1][2:0];
         f.args[7] = 8'(n);
         base = spi_model.sent_q.size();
         send_frame(f);
         waited = 0;
         while (!spi_tx_dv && waited < 100) begin
            @(posedge clk50);
            waited++;
         end
         if (!spi_tx_dv)
            report_failure("spi transfer never started");
         check_byte("cs during transfer", 8'hff ^ (8'h01 << cs), spi_cs);
         check_byte("miso select", {5'd0, cs}, {5'd0, spi_miso_sel});
         get_rsp(0, word);
         check_byte("cs after transfer", 8'hff, spi_cs);
         check_word("bytes sent", n, spi_model.sent_q.size() - base);
         for (int i = 0; i < n && base + i < spi_model.sent_q.size(); i++)
            check_byte("sent byte", f.args[2 + i], spi_model.sent_q[base + i]);
         check_word("spi response",
                    {16'd0, f.args[3] ^ 8'h5a, f.args[1 + n] ^ 8'h5a}, word);
      end
      end_test();
   endtask

   task automatic test_stall_unknown();
      cmd_frame_t  f;
      logic [31:0] word;
      begin_test("stall_unknown");
      for (int n = 0; n < 3; n++) begin
         f = rand_frame(OP_READ_REG);
         f.args[1] = REG_VERSION;
         run_cmd(f, 2 + int'(rand_bits(3)), word);
         check_word("version under stall", EXP_VERSION, word);
         repeat (20) begin
            @(posedge clk50);
            if (out_tvalid)
               report_failure("a second beat followed an accepted response");
         end
      end
      f = rand_frame(OP_STATUS);
      f.op = cmd_op_e'(8'h55);  // not a kept opcode
      send_frame(f);
      repeat (100) begin
         @(posedge clk50);
         if (out_tvalid)
            report_failure("a frame with an unknown opcode got a response");
      end
      if (!in_tready)
         report_failure("decoder did not return to receiving after a dropped frame");
      f = rand_frame(OP_STATUS);
      f.args[1] = ST_VERSION;
      run_cmd(f, 0, word);
      check_word("frame after drop", EXP_VERSION, word);
      end_test();
   endtask

   initial begin
      #(N_TESTS * 2000);
      $display("watchdog expired before the tests finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin
      pllreset2  = 1'b1;
      in_tvalid  = 1'b0;
      in_tdata   = '0;
      out_tready = 1'b0;
      boardin    = '0;
      repeat (3) @(posedge clk50);
      pllreset2 <= 1'b0;
      @(posedge clk50);
      test_status_read();
      test_trigger();
      test_ds_board();
      test_spi();
      test_stall_unknown();
      $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, errors);
      if (errors == 0)
         $display("*** TEST PASSED ***");
      else
         $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* bench/spi_master_model.sv */
// behavioral spi byte master
// takes 4 cycles per byte and answers each byte with byte ^ 8'h5a
`timescale 1ns/1ns
`default_nettype none

module spi_master_model (
   input  wire        clk50,
   input  wire        pllreset2,
   input  wire  [7:0] i_tx,
   input  wire        i_tx_dv,
   output logic       o_tx_ready,
   output logic       o_rx_dv,
   output logic [7:0] o_rx
);

   logic [7:0] sent_q[$];  // every byte handed over, in order
   logic [7:0] cur_byte;
   logic [2:0] busy_cnt;

   always @(posedge clk50) begin
      if (pllreset2) begin
         o_tx_ready <= 1'b1;
         o_rx_dv    <= 1'b0;
         o_rx       <= '0;
         busy_cnt   <= '0;
         cur_byte   <= '0;
      end else begin
         o_rx_dv <= 1'b0;
         if (busy_cnt != 3'd0) begin
            busy_cnt <= busy_cnt - 3'd1;
            if (busy_cnt == 3'd1) begin
               o_rx       <= cur_byte ^ 8'h5a;  // slave reply
               o_rx_dv    <= 1'b1;
               o_tx_ready <= 1'b1;
            end
         end else if (i_tx_dv) begin
            sent_q.push_back(i_tx);
            cur_byte   <= i_tx;
            busy_cnt   <= 3'd4;
            o_tx_ready <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

/* design/command_processor_top.sv */
// usb command processor
// frame decoder feeding the settings and spi units, one response per command
`timescale 1ns/1ns
`default_nettype none

module command_processor_top (
   input  wire                  clk50,
   input  wire                  pllreset2,
   input  wire                  i_in_tvalid,
   input  wire  [7:0]           i_in_tdata,
   output logic                 o_in_tready,
   input  wire                  i_out_tready,
   output logic                 o_out_tvalid,
   output logic [31:0]          o_out_tdata,
   output logic [3:0]           o_out_tkeep,
   output logic                 o_out_tlast,
   input  wire  [7:0]           i_boardin,
   output cmd_pkg::trig_cfg_t   o_trig,
   output cmd_pkg::acq_cfg_t    o_acq,
   output logic [7:0]           o_boardout,
   output logic                 o_fan_on,
   output logic [1:0]           o_spi_mode,
   output logic                 o_spi_reset_l,
   input  wire                  i_spi_tx_ready,
   input  wire                  i_spi_rx_dv,
   input  wire  [7:0]           i_spi_rx,
   output logic [7:0]           o_spi_tx,
   output logic                 o_spi_tx_dv,
   output logic [cmd_pkg::N_SPI_CS-1:0] o_spi_cs,
   output logic [2:0]           o_spi_miso_sel
);
   import cmd_pkg::*;

   cmd_frame_t frame;
   logic       set_go;
   logic       spi_go;
   logic       rsp_done;
   rsp_t       set_rsp;
   rsp_t       spi_rsp;

   cmd_frame_decoder u_decoder (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_in_tvalid(i_in_tvalid), .i_in_tdata(i_in_tdata), .o_in_tready(o_in_tready),
      .i_rsp_done(rsp_done), .o_frame(frame), .o_set_go(set_go), .o_spi_go(spi_go)
   );

   settings_executor u_settings (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_set_go(set_go), .i_frame(frame), .i_boardin(i_boardin), .o_rsp(set_rsp),
      .o_trig(o_trig), .o_acq(o_acq), .o_boardout(o_boardout), .o_fan_on(o_fan_on),
      .o_spi_mode(o_spi_mode), .o_spi_reset_l(o_spi_reset_l)
   );

   spi_transfer_seq u_spi (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_spi_go(spi_go), .i_frame(frame),
      .i_spi_tx_ready(i_spi_tx_ready), .i_spi_rx_dv(i_spi_rx_dv), .i_spi_rx(i_spi_rx),
      .o_spi_tx(o_spi_tx), .o_spi_tx_dv(o_spi_tx_dv), .o_spi_cs(o_spi_cs),
      .o_spi_miso_sel(o_spi_miso_sel), .o_rsp(spi_rsp)
   );

   usb_response_tx u_rsp_tx (
      .clk50(clk50), .pllreset2(pllreset2),
      .i_set_rsp(set_rsp), .i_spi_rsp(spi_rsp), .i_out_tready(i_out_tready),
      .o_out_tvalid(o_out_tvalid), .o_out_tdata(o_out_tdata), .o_out_tkeep(o_out_tkeep),
      .o_out_tlast(o_out_tlast), .o_rsp_done(rsp_done)
   );

endmodule

`default_nettype wire

/* design/usb_response_tx.sv */
// usb response transmitter
// holds one 32-bit response beat on the outgoing stream until it is taken
`timescale 1ns/1ns
`default_nettype none

module usb_response_tx (
   input  wire           clk50,
   input  wire           pllreset2,
   input  cmd_pkg::rsp_t i_set_rsp,
   input  cmd_pkg::rsp_t i_spi_rsp,
   input  wire           i_out_tready,
   output logic          o_out_tvalid,
   output logic [31:0]   o_out_tdata,
   output logic [3:0]    o_out_tkeep,
   output logic          o_out_tlast,
   output logic          o_rsp_done
);

   // every response is a single full word
   assign o_out_tkeep = 4'b1111;
   assign o_out_tlast = 1'b1;
   assign o_rsp_done  = o_out_tvalid && i_out_tready;

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         o_out_tvalid <= 1'b0;
         o_out_tdata  <= '0;
      end else if (i_set_rsp.valid) begin
         o_out_tvalid <= 1'b1;
         o_out_tdata  <= i_set_rsp.data;
      end else if (i_spi_rsp.valid) begin
         o_out_tvalid <= 1'b1;
         o_out_tdata  <= i_spi_rsp.data;
      end else if (o_rsp_done) begin
         o_out_tvalid <= 1'b0;
      end
   end

   // the decoder lets only one command run at a time
   a_one_rsp: assert property (@(posedge clk50) disable iff (pllreset2)
      !(i_set_rsp.valid && i_spi_rsp.valid));

   a_hold_data: assert property (@(posedge clk50) disable iff (pllreset2)
      o_out_tvalid && !i_out_tready |=> o_out_tvalid && $stable(o_out_tdata));

endmodule

`default_nettype wire

/* design/spi_transfer_seq.sv */
// spi transfer sequencer
// drives chip select and 2 to 4 bytes through the spi byte master
`timescale 1ns/1ns
`default_nettype none

module spi_transfer_seq (
   input  wire                   clk50,
   input  wire                   pllreset2,
   input  wire                   i_spi_go,
   input  cmd_pkg::cmd_frame_t   i_frame,
   input  wire                   i_spi_tx_ready,
   input  wire                   i_spi_rx_dv,
   input  wire  [7:0]            i_spi_rx,
   output logic [7:0]            o_spi_tx,
   output logic                  o_spi_tx_dv,
   output logic [cmd_pkg::N_SPI_CS-1:0] o_spi_cs,
   output logic [2:0]            o_spi_miso_sel,
   output cmd_pkg::rsp_t         o_rsp
);
   import cmd_pkg::*;

   typedef enum logic [2:0] {
      SPI_IDLE, SPI_CS_SETUP, SPI_SEND, SPI_WAIT_RX, SPI_CS_HOLD
   } spi_state_e;

   spi_state_e state;
   logic [5:0] wait_cnt;   // cs setup and hold delay
   logic [1:0] byte_idx;   // byte being sent, 0 is args2
   logic [1:0] last_idx;

   // args7 holds the byte count, anything odd acts as 2
   always_comb begin
      case (i_frame.args[7])
         8'd3:    last_idx = 2'd2;
         8'd4:    last_idx = 2'd3;
         default: last_idx = 2'd1;
      endcase
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state          <= SPI_IDLE;
         wait_cnt       <= '0;
         byte_idx       <= '0;
         o_spi_tx       <= '0;
         o_spi_tx_dv    <= 1'b0;
         o_spi_cs       <= '1;
         o_spi_miso_sel <= '0;
         o_rsp          <= '0;
      end else begin
         o_rsp.valid <= 1'b0;
         case (state)
            SPI_IDLE: begin
               if (i_spi_go) begin
                  o_spi_cs[i_frame.args[1][2:0]] <= 1'b0;
                  o_spi_miso_sel <= i_frame.args[1][2:0];
                  o_rsp.data     <= '0;
                  wait_cnt       <= '0;
                  byte_idx       <= '0;
                  state          <= SPI_CS_SETUP;
               end
            end
            SPI_CS_SETUP: begin
               if (wait_cnt == 6'(CS_SETUP_CYCLES - 1)) begin
                  wait_cnt <= '0;
                  state    <= SPI_SEND;
               end else begin
                  wait_cnt <= wait_cnt + 6'd1;
               end
            end
            SPI_SEND: begin
               if (i_spi_tx_ready) begin
                  o_spi_tx    <= i_frame.args[3'(byte_idx) + 3'd2];
                  o_spi_tx_dv <= 1'b1;
                  state       <= SPI_WAIT_RX;
               end
            end
            SPI_WAIT_RX: begin
               o_spi_tx_dv <= 1'b0;
               if (i_spi_rx_dv) begin
                  if (byte_idx == 2'd1)
                     o_rsp.data[15:8] <= i_spi_rx;  // read during second byte
                  if (byte_idx == last_idx) begin
                     o_rsp.data[7:0] <= i_spi_rx;
                     state           <= SPI_CS_HOLD;
                  end else begin
                     byte_idx <= byte_idx + 2'd1;
                     state    <= SPI_SEND;
                  end
               end
            end
            SPI_CS_HOLD: begin
               if (wait_cnt == 6'(CS_HOLD_CYCLES - 1)) begin
                  wait_cnt    <= '0;
                  o_spi_cs    <= '1;
                  o_rsp.valid <= 1'b1;
                  state       <= SPI_IDLE;
               end else begin
                  wait_cnt <= wait_cnt + 6'd1;
               end
            end
            default: state <= SPI_IDLE;
         endcase
      end
   end

   a_dv_pulse: assert property (@(posedge clk50) disable iff (pllreset2)
      o_spi_tx_dv |=> !o_spi_tx_dv);

endmodule

`default_nettype wire

/* design/settings_executor.sv */
// settings execute unit
// applies trigger, acquisition, board and spi mode settings, answers reads
`timescale 1ns/1ns
`default_nettype none

module settings_executor (
   input  wire                 clk50,
   input  wire                 pllreset2,
   input  wire                 i_set_go,
   input  cmd_pkg::cmd_frame_t i_frame,
   input  wire  [7:0]          i_boardin,
   output cmd_pkg::rsp_t       o_rsp,
   output cmd_pkg::trig_cfg_t  o_trig,
   output cmd_pkg::acq_cfg_t   o_acq,
   output logic [7:0]          o_boardout,
   output logic                o_fan_on,
   output logic [1:0]          o_spi_mode,
   output logic                o_spi_reset_l
);
   import cmd_pkg::*;

   logic [7:0]  boardin_sync;
   logic [11:0] thr_diff;
   logic [11:0] thr_sum;
   logic [11:0] lower_new;
   logic [11:0] upper_new;
   logic [31:0] reg_word;
   logic [31:0] status_word;

   // threshold arithmetic stays 12 bits wide, as in the triggerer
   always_comb begin
      thr_diff  = 12'(i_frame.args[1]) - 12'(i_frame.args[2]) - 12'(THRESH_MIDSCALE);
      thr_sum   = 12'(i_frame.args[1]) + 12'(i_frame.args[2]) - 12'(THRESH_MIDSCALE);
      lower_new = (thr_diff << THRESH_SHIFT) + 12'(THRESH_ROUND);
      upper_new = (thr_sum << THRESH_SHIFT) + 12'(THRESH_ROUND);
   end

   always_comb begin
      case (i_frame.args[1])
         REG_PREOFFSET: reg_word = {22'd0, o_trig.preoffset};
         REG_VERSION:   reg_word = FW_VERSION;
         REG_BOARDIN:   reg_word = {24'd0, boardin_sync};
         REG_DSMERGE:   reg_word = {24'd0, o_acq.ds_merge};
         REG_DS:        reg_word = {27'd0, o_acq.downsample};
         REG_HIGHRES:   reg_word = {31'd0, o_acq.highres};
         REG_UPPER:     reg_word = {20'd0, o_trig.upper_thresh};
         default:       reg_word = '0;
      endcase
   end

   always_comb begin
      case (i_frame.args[1])
         ST_VERSION: status_word = FW_VERSION;
         ST_BOARDIN: status_word = {24'd0, boardin_sync};
         ST_FAN:     status_word = {31'd0, o_fan_on};  // value before the write
         default:    status_word = '0;
      endcase
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         boardin_sync  <= '0;
         o_rsp         <= '0;
         o_trig        <= '0;
         o_acq         <= '0;
         o_boardout    <= '0;
         o_fan_on      <= 1'b0;
         o_spi_mode    <= '0;
         o_spi_reset_l <= 1'b1;
      end else begin
         boardin_sync  <= i_boardin;  // board pins are asynchronous
         o_rsp.valid   <= i_set_go;
         o_spi_reset_l <= 1'b1;       // low for one cycle per mode change
         if (i_set_go) begin
            case (i_frame.op)
               OP_TRIG_SET: begin
                  o_trig.lower_thresh <= lower_new;
                  o_trig.upper_thresh <= upper_new;
                  o_trig.preoffset    <= {i_frame.args[3][1:0], i_frame.args[4]};
                  o_trig.tot          <= i_frame.args[5];
                  o_trig.chan         <= i_frame.args[6][0];
                  o_rsp.data          <= 32'(OP_TRIG_SET);
               end
               OP_DS_SET: begin
                  o_acq.downsample <= i_frame.args[1][4:0];
                  o_acq.highres    <= i_frame.args[2][0];
                  o_acq.ds_merge   <= i_frame.args[3];
                  o_rsp.data       <= 32'(OP_DS_SET);
               end
               OP_BOARDOUT: begin
                  o_boardout[i_frame.args[1][2:0]] <= i_frame.args[2][0];
                  o_rsp.data <= {24'd0, o_boardout};  // old byte
               end
               OP_SPI_MODE: begin
                  o_spi_mode    <= i_frame.args[1][1:0];
                  o_spi_reset_l <= 1'b0;  // restart the spi master
                  o_rsp.data    <= {24'd0, i_frame.args[1]};
               end
               OP_STATUS: begin
                  if (i_frame.args[1] == ST_FAN)
                     o_fan_on <= i_frame.args[2][0];
                  o_rsp.data <= status_word;
               end
               OP_READ_REG: o_rsp.data <= reg_word;
               default:     o_rsp.data <= '0;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

/* design/cmd_frame_decoder.sv */
// command frame decoder
// collects 8-byte frames from the byte stream and starts one execute unit
`timescale 1ns/1ns
`default_nettype none

module cmd_frame_decoder (
   input  wire                 clk50,
   input  wire                 pllreset2,
   input  wire                 i_in_tvalid,
   input  wire  [7:0]          i_in_tdata,
   output logic                o_in_tready,
   input  wire                 i_rsp_done,
   output cmd_pkg::cmd_frame_t o_frame,
   output logic                o_set_go,
   output logic                o_spi_go
);
   import cmd_pkg::*;

   typedef enum logic [1:0] {RECEIVE, DISPATCH, WAIT_RSP} dec_state_e;

   dec_state_e state;
   logic [2:0] byte_cnt;  // next byte position in the frame
   logic       op_known;
   logic       take;

   assign o_in_tready = (state == RECEIVE);
   assign take        = i_in_tvalid && o_in_tready;

   always_comb begin
      case (o_frame.op)
         OP_STATUS, OP_SPI, OP_SPI_MODE, OP_TRIG_SET,
         OP_DS_SET, OP_BOARDOUT, OP_READ_REG: op_known = 1'b1;
         default: op_known = 1'b0;
      endcase
   end

   // strobes only live for the single dispatch cycle
   assign o_spi_go = (state == DISPATCH) && (o_frame.op == OP_SPI);
   assign o_set_go = (state == DISPATCH) && (o_frame.op != OP_SPI);

   // frame bytes land in place
   always_ff @(posedge clk50) begin
      if (take) begin
         if (byte_cnt == 3'd0)
            o_frame.op <= cmd_op_e'(i_in_tdata);
         else
            o_frame.args[byte_cnt] <= i_in_tdata;
      end
   end

   always_ff @(posedge clk50) begin
      if (pllreset2) begin
         state    <= RECEIVE;
         byte_cnt <= '0;
      end else begin
         case (state)
            RECEIVE: begin
               if (take) begin
                  byte_cnt <= byte_cnt + 3'd1;  // wraps after byte 7
                  if (byte_cnt == 3'(FRAME_BYTES - 1)) begin
                     // op byte arrived first and is already stored
                     if (op_known)
                        state <= DISPATCH;
                  end
               end
            end
            DISPATCH: state <= WAIT_RSP;
            WAIT_RSP: begin
               if (i_rsp_done)
                  state <= RECEIVE;
            end
            default: state <= RECEIVE;
         endcase
      end
   end

   // dropped frames never start an execute unit
   a_go_known: assert property (@(posedge clk50) disable iff (pllreset2)
      (o_set_go || o_spi_go) |-> op_known);

endmodule

`default_nettype wire

/* design/cmd_pkg.sv */
// command processor shared definitions
// opcodes, frame and config structs, response word and constants
`default_nettype none

package cmd_pkg;

   // kept opcodes, byte 0 of each frame
   typedef enum logic [7:0] {
      OP_STATUS   = 8'd2,
      OP_SPI      = 8'd3,
      OP_SPI_MODE = 8'd4,
      OP_TRIG_SET = 8'd8,
      OP_DS_SET   = 8'd9,
      OP_BOARDOUT = 8'd10,
      OP_READ_REG = 8'd14
   } cmd_op_e;

   typedef struct packed {
      cmd_op_e          op;    // byte 0
      logic [7:1][7:0]  args;  // bytes 1 to 7
   } cmd_frame_t;

   typedef struct packed {
      logic signed [11:0] lower_thresh;
      logic signed [11:0] upper_thresh;
      logic [7:0]         tot;         // time over threshold
      logic               chan;
      logic [9:0]         preoffset;
   } trig_cfg_t;

   typedef struct packed {
      logic [4:0] downsample;
      logic       highres;
      logic [7:0] ds_merge;
   } acq_cfg_t;

   typedef struct packed {
      logic        valid;  // one-cycle strobe
      logic [31:0] data;
   } rsp_t;

   localparam logic [31:0] FW_VERSION = 32'd26;
   localparam int FRAME_BYTES = 8;

   // threshold rule: ((a -/+ b - midscale) << shift) + round
   localparam int THRESH_MIDSCALE = 128;
   localparam int THRESH_SHIFT    = 4;
   localparam int THRESH_ROUND    = 8;

   localparam int CS_SETUP_CYCLES = 11;
   localparam int CS_HOLD_CYCLES  = 36;
   localparam int N_SPI_CS        = 8;

   // status sub-codes, args1 of OP_STATUS
   localparam logic [7:0] ST_VERSION = 8'd0;
   localparam logic [7:0] ST_BOARDIN = 8'd1;
   localparam logic [7:0] ST_FAN     = 8'd6;

   // register numbers, args1 of OP_READ_REG
   localparam logic [7:0] REG_PREOFFSET = 8'd0;
   localparam logic [7:0] REG_VERSION   = 8'd3;
   localparam logic [7:0] REG_BOARDIN   = 8'd4;
   localparam logic [7:0] REG_DSMERGE   = 8'd9;
   localparam logic [7:0] REG_DS        = 8'd10;
   localparam logic [7:0] REG_HIGHRES   = 8'd11;
   localparam logic [7:0] REG_UPPER     = 8'd12;

endpackage

`default_nettype wire
